/* design/stamofu_settings.svh */
// --------------------
// store-amo-fence unit build settings
// queue depth and ROB index width
// --------------------

`ifndef STAMOFU_SETTINGS_SVH
`define STAMOFU_SETTINGS_SVH

// acquire queue depth
// also valid at 2, 8 and 16
`define STAMOFU_AQ_ENTRIES 4

// absolute ROB index width
`define LOG_ROB_ENTRIES 7

`endif

/* design/stamofu_pkg.sv */
// --------------------
// store-amo-fence unit types
// ROB index, op kinds and the acquire advertisement
// --------------------

`include "stamofu_settings.svh"

package stamofu_pkg;

    // absolute ROB index
    typedef logic [`LOG_ROB_ENTRIES-1:0] rob_index_t;

    // dispatched op kinds seen by the unit
    typedef enum logic [1:0] {
        OP_STORE = 2'd0,
        OP_AMO   = 2'd1,
        OP_FENCE = 2'd2
    } stamofu_op_e;

    // oldest live acquires
    // an index field only means something while its active bit is set
    typedef struct packed {
        logic       mem_active;
        rob_index_t mem_oldest;
        logic       io_active;
        rob_index_t io_oldest;
    } aq_advert_t;

endpackage

/* design/stamofu_aq_if.sv */
// --------------------
// acquire queue interfaces
// entry write strobe and oldest-acquire advertisement
// --------------------

`timescale 1ns/1ps

// single-cycle entry write, used for enqueue and for the update banks
interface aq_entry_if;

    logic                    valid;
    logic                    mem_aq;
    logic                    io_aq;
    stamofu_pkg::rob_index_t rob_index;

    modport src (
        output valid,
        output mem_aq,
        output io_aq,
        output rob_index
    );

    modport dst (
        input valid,
        input mem_aq,
        input io_aq,
        input rob_index
    );

endinterface

// advertisement level, refreshed every cycle
interface aq_advert_if;

    stamofu_pkg::aq_advert_t advert;

    modport src (
        output advert
    );

    modport dst (
        input advert
    );

endinterface

/* design/pe_lsb.sv */
// --------------------
// lowest-set-bit priority encoder
// one-hot grant plus binary index of the winner
// --------------------

`timescale 1ns/1ps

module pe_lsb #(
    // at least 2 so the index has a bit
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [WIDTH-1:0]         ack_one_hot,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    localparam int IDX_W = $clog2(WIDTH);

    // x & -x isolates the lowest set bit
    // no request gives zero
    assign ack_one_hot = req_vec & (~req_vec + WIDTH'(1));

    // scan down from the top so the lowest hit is written last
    always_comb begin
        ack_index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                ack_index = IDX_W'(i);
            end
        end
    end

endmodule

/* design/stamofu_dispatch.sv */
// --------------------
// acquire queue dispatch stage
// decodes acquire semantics and registers one enqueue
// --------------------

`timescale 1ns/1ps

module stamofu_dispatch (
    input  logic                       CLK,
    input  logic                       nRST,

    // dispatched op
    input  logic                       dispatch_valid,
    input  stamofu_pkg::stamofu_op_e   dispatch_op,
    input  logic                       dispatch_aq,
    input  logic                       dispatch_fence_mem,
    input  logic                       dispatch_fence_io,
    input  stamofu_pkg::rob_index_t    dispatch_rob_index,

    // registered enqueue towards the queue
    aq_entry_if.src                    enq,
    output logic                       pending
);

    // decoded acquire flags
    logic dec_mem_aq;
    logic dec_io_aq;

    // dispatch register
    logic                    valid_q;
    logic                    mem_aq_q;
    logic                    io_aq_q;
    stamofu_pkg::rob_index_t rob_index_q;

    // --------------------
    // decode
    // --------------------

    always_comb begin
        dec_mem_aq = 1'b0;
        dec_io_aq  = 1'b0;
        case (dispatch_op)
            // plain store never acquires
            stamofu_pkg::OP_STORE: begin
                dec_mem_aq = 1'b0;
                dec_io_aq  = 1'b0;
            end
            // IO target is only known after translation
            stamofu_pkg::OP_AMO: begin
                dec_mem_aq = dispatch_aq;
                dec_io_aq  = 1'b0;
            end
            // fence orders later ops by its predecessor bits
            stamofu_pkg::OP_FENCE: begin
                dec_mem_aq = dispatch_fence_mem;
                dec_io_aq  = dispatch_fence_io;
            end
            default: begin
                dec_mem_aq = 1'b0;
                dec_io_aq  = 1'b0;
            end
        endcase
    end

    // --------------------
    // dispatch register
    // --------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dispatch_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (dispatch_valid) begin
            mem_aq_q    <= dec_mem_aq;
            io_aq_q     <= dec_io_aq;
            rob_index_q <= dispatch_rob_index;
        end
    end

    assign enq.valid     = valid_q;
    assign enq.mem_aq    = mem_aq_q;
    assign enq.io_aq     = io_aq_q;
    assign enq.rob_index = rob_index_q;

    // queue must reserve a slot for the op held here
    assign pending = valid_q;

endmodule

/* design/stamofu_aq.sv */
// --------------------
// store-amo-fence acquire queue
// in-order shifting queue of acquire flags with kill and update
// advertises the oldest live memory and IO acquire
// --------------------

`timescale 1ns/1ps
`include "stamofu_settings.svh"

module stamofu_aq #(
    parameter int ENTRIES = `STAMOFU_AQ_ENTRIES
) (
    input  logic                    CLK,
    input  logic                    nRST,

    // enqueue from the dispatch register
    aq_entry_if.dst                 enq,
    input  logic                    pending,
    output logic                    enq_ready,

    // late update banks
    aq_entry_if.dst                 upd0,
    aq_entry_if.dst                 upd1,

    // dequeue
    input  logic                    deq_valid,
    output stamofu_pkg::rob_index_t deq_rob_index,

    // ROB head and flush
    input  stamofu_pkg::rob_index_t rob_head_index,
    input  logic                    rob_kill_valid,
    input  stamofu_pkg::rob_index_t rob_kill_rel_index,

    // registered advertisement
    aq_advert_if.src                advert
);

    localparam int IDX_W = $clog2(ENTRIES);

    // entry state, oldest at index 0
    logic [ENTRIES-1:0]                    valid_q;
    logic [ENTRIES-1:0]                    killed_q;
    logic [ENTRIES-1:0]                    mem_aq_q;
    logic [ENTRIES-1:0]                    io_aq_q;
    stamofu_pkg::rob_index_t [ENTRIES-1:0] rob_index_q;

    // per-entry events this cycle
    stamofu_pkg::rob_index_t [ENTRIES-1:0] rel_index;
    logic [ENTRIES-1:0]                    new_killed;
    logic [ENTRIES-1:0]                    upd0_hit;
    logic [ENTRIES-1:0]                    upd1_hit;

    // entries with events applied, plus an empty slot on top
    logic [ENTRIES:0]                      valid_x;
    logic [ENTRIES:0]                      killed_x;
    logic [ENTRIES:0]                      mem_aq_x;
    logic [ENTRIES:0]                      io_aq_x;
    logic [ENTRIES:0]                      enq_x;
    stamofu_pkg::rob_index_t [ENTRIES:0]   rob_index_x;

    // what each entry takes, self or the one above
    logic [ENTRIES-1:0]                    src_valid;
    logic [ENTRIES-1:0]                    src_killed;
    logic [ENTRIES-1:0]                    src_mem_aq;
    logic [ENTRIES-1:0]                    src_io_aq;
    logic [ENTRIES-1:0]                    src_enq;
    stamofu_pkg::rob_index_t [ENTRIES-1:0] src_rob_index;

    // enqueue slot
    logic [ENTRIES-1:0]                    open_vec;
    logic [ENTRIES-1:0]                    enq_slot_one_hot;
    logic [IDX_W-1:0]                      enq_slot_index;

    // advertisement search
    logic [ENTRIES-1:0]                    mem_req_vec;
    logic [ENTRIES-1:0]                    io_req_vec;
    logic [IDX_W-1:0]                      mem_index;
    logic [IDX_W-1:0]                      io_index;
    stamofu_pkg::aq_advert_t               advert_q;

    // --------------------
    // kill and update match
    // --------------------

    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            // age relative to the ROB head survives wraparound
            rel_index[i]  = rob_index_q[i] - rob_head_index;
            new_killed[i] = rob_kill_valid & (rel_index[i] > rob_kill_rel_index);
            upd0_hit[i]   = upd0.valid & (upd0.rob_index == rob_index_q[i]);
            upd1_hit[i]   = upd1.valid & (upd1.rob_index == rob_index_q[i]);
        end
    end

    always_comb begin
        valid_x     = {1'b0, valid_q};
        killed_x    = {1'b0, killed_q | new_killed};
        enq_x       = {1'b0, enq_slot_one_hot & {ENTRIES{enq.valid}}};
        rob_index_x = {stamofu_pkg::rob_index_t'(0), rob_index_q};
        mem_aq_x[ENTRIES] = 1'b0;
        io_aq_x[ENTRIES]  = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            // bank 0 has priority
            if (upd0_hit[i]) begin
                mem_aq_x[i] = upd0.mem_aq;
                io_aq_x[i]  = upd0.io_aq;
            end else if (upd1_hit[i]) begin
                mem_aq_x[i] = upd1.mem_aq;
                io_aq_x[i]  = upd1.io_aq;
            end else begin
                mem_aq_x[i] = mem_aq_q[i];
                io_aq_x[i]  = io_aq_q[i];
            end
        end
    end

    // dequeue shifts every entry down by one
    assign src_valid     = deq_valid ? valid_x[ENTRIES:1]     : valid_x[ENTRIES-1:0];
    assign src_killed    = deq_valid ? killed_x[ENTRIES:1]    : killed_x[ENTRIES-1:0];
    assign src_mem_aq    = deq_valid ? mem_aq_x[ENTRIES:1]    : mem_aq_x[ENTRIES-1:0];
    assign src_io_aq     = deq_valid ? io_aq_x[ENTRIES:1]     : io_aq_x[ENTRIES-1:0];
    assign src_enq       = deq_valid ? enq_x[ENTRIES:1]       : enq_x[ENTRIES-1:0];
    assign src_rob_index = deq_valid ? rob_index_x[ENTRIES:1] : rob_index_x[ENTRIES-1:0];

    // --------------------
    // enqueue slot
    // --------------------

    assign open_vec = ~valid_q;

    pe_lsb #(
        .WIDTH(ENTRIES)
    ) enq_pe (
        .req_vec(open_vec),
        .ack_one_hot(enq_slot_one_hot),
        .ack_index(enq_slot_index)
    );

    // valid entries stay packed at the bottom
    // so a first free slot at the top means exactly one is free
    assign enq_ready = (|open_vec)
        & ((enq_slot_index != IDX_W'(ENTRIES - 1)) | ~pending);

    // --------------------
    // entry registers
    // --------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q     <= '0;
            killed_q    <= '0;
            mem_aq_q    <= '0;
            io_aq_q     <= '0;
            rob_index_q <= '0;
        end else begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (src_valid[i]) begin
                    valid_q[i]     <= 1'b1;
                    killed_q[i]    <= src_killed[i];
                    mem_aq_q[i]    <= src_mem_aq[i];
                    io_aq_q[i]     <= src_io_aq[i];
                    rob_index_q[i] <= src_rob_index[i];
                end else if (src_enq[i]) begin
                    // new op lands in the lowest free slot
                    valid_q[i]     <= 1'b1;
                    killed_q[i]    <= 1'b0;
                    mem_aq_q[i]    <= enq.mem_aq;
                    io_aq_q[i]     <= enq.io_aq;
                    rob_index_q[i] <= enq.rob_index;
                end else begin
                    valid_q[i]     <= 1'b0;
                    killed_q[i]    <= 1'b0;
                end
            end
        end
    end

    assign deq_rob_index = rob_index_q[0];

    // --------------------
    // advertisement
    // --------------------

    // killed entries linger until dequeued but never advertise
    assign mem_req_vec = valid_q & ~killed_q & mem_aq_q;
    assign io_req_vec  = valid_q & ~killed_q & io_aq_q;

    pe_lsb #(
        .WIDTH(ENTRIES)
    ) mem_pe (
        .req_vec(mem_req_vec),
        .ack_one_hot(),
        .ack_index(mem_index)
    );

    pe_lsb #(
        .WIDTH(ENTRIES)
    ) io_pe (
        .req_vec(io_req_vec),
        .ack_one_hot(),
        .ack_index(io_index)
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            advert_q <= '0;
        end else begin
            advert_q.mem_active <= |mem_req_vec;
            advert_q.mem_oldest <= rob_index_q[mem_index];
            advert_q.io_active  <= |io_req_vec;
            advert_q.io_oldest  <= rob_index_q[io_index];
        end
    end

    assign advert.advert = advert_q;

endmodule

/* design/stamofu_load_gate.sv */
// --------------------
// acquire load gate
// stalls loads younger than the oldest live acquire
// --------------------

`timescale 1ns/1ps

module stamofu_load_gate (
    // advertisement from the acquire queue
    aq_advert_if.dst                advert,
    input  stamofu_pkg::rob_index_t rob_head_index,

    // load query
    input  logic                    ld_valid,
    input  logic                    ld_is_io,
    input  stamofu_pkg::rob_index_t ld_rob_index,
    output logic                    ld_stall
);

    // acquire that orders this load
    logic                    aq_active;
    stamofu_pkg::rob_index_t aq_index;

    // ages relative to the ROB head
    stamofu_pkg::rob_index_t aq_rel;
    stamofu_pkg::rob_index_t ld_rel;

    // --------------------
    // select by load kind
    // --------------------

    // IO loads wait on IO acquires and memory loads on memory acquires
    assign aq_active = ld_is_io ? advert.advert.io_active : advert.advert.mem_active;
    assign aq_index  = ld_is_io ? advert.advert.io_oldest : advert.advert.mem_oldest;

    // --------------------
    // age compare
    // --------------------

    // subtract the head so the compare holds across index wraparound
    assign aq_rel = aq_index - rob_head_index;
    assign ld_rel = ld_rob_index - rob_head_index;

    // only a strictly older acquire blocks the load
    assign ld_stall = ld_valid & aq_active & (aq_rel < ld_rel);

endmodule

/* design/stamofu_aq_top.sv */
// --------------------
// acquire tracking top level
// dispatch stage, acquire queue and load gate
// --------------------

`timescale 1ns/1ps

module stamofu_aq_top (
    input  logic                     CLK,
    input  logic                     nRST,

    // dispatch
    input  logic                     dispatch_valid,
    input  stamofu_pkg::stamofu_op_e dispatch_op,
    input  logic                     dispatch_aq,
    input  logic                     dispatch_fence_mem,
    input  logic                     dispatch_fence_io,
    input  stamofu_pkg::rob_index_t  dispatch_rob_index,
    output logic                     enq_ready,

    // update bank 0
    input  logic                     upd0_valid,
    input  logic                     upd0_mem_aq,
    input  logic                     upd0_io_aq,
    input  stamofu_pkg::rob_index_t  upd0_rob_index,

    // update bank 1
    input  logic                     upd1_valid,
    input  logic                     upd1_mem_aq,
    input  logic                     upd1_io_aq,
    input  stamofu_pkg::rob_index_t  upd1_rob_index,

    // dequeue and ROB
    input  logic                     deq_valid,
    output stamofu_pkg::rob_index_t  deq_rob_index,
    input  stamofu_pkg::rob_index_t  rob_head_index,
    input  logic                     rob_kill_valid,
    input  stamofu_pkg::rob_index_t  rob_kill_rel_index,

    // advertisement
    output logic                     mem_active,
    output stamofu_pkg::rob_index_t  mem_oldest,
    output logic                     io_active,
    output stamofu_pkg::rob_index_t  io_oldest,

    // load query
    input  logic                     ld_valid,
    input  logic                     ld_is_io,
    input  stamofu_pkg::rob_index_t  ld_rob_index,
    output logic                     ld_stall
);

    logic pending;

    aq_entry_if  enq_if ();
    aq_entry_if  upd0_if ();
    aq_entry_if  upd1_if ();
    aq_advert_if advert_if ();

    assign upd0_if.valid     = upd0_valid;
    assign upd0_if.mem_aq    = upd0_mem_aq;
    assign upd0_if.io_aq     = upd0_io_aq;
    assign upd0_if.rob_index = upd0_rob_index;

    assign upd1_if.valid     = upd1_valid;
    assign upd1_if.mem_aq    = upd1_mem_aq;
    assign upd1_if.io_aq     = upd1_io_aq;
    assign upd1_if.rob_index = upd1_rob_index;

    stamofu_dispatch dispatch_inst (
        .CLK(CLK),
        .nRST(nRST),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_aq(dispatch_aq),
        .dispatch_fence_mem(dispatch_fence_mem),
        .dispatch_fence_io(dispatch_fence_io),
        .dispatch_rob_index(dispatch_rob_index),
        .enq(enq_if),
        .pending(pending)
    );

    stamofu_aq aq_inst (
        .CLK(CLK),
        .nRST(nRST),
        .enq(enq_if),
        .pending(pending),
        .enq_ready(enq_ready),
        .upd0(upd0_if),
        .upd1(upd1_if),
        .deq_valid(deq_valid),
        .deq_rob_index(deq_rob_index),
        .rob_head_index(rob_head_index),
        .rob_kill_valid(rob_kill_valid),
        .rob_kill_rel_index(rob_kill_rel_index),
        .advert(advert_if)
    );

    stamofu_load_gate load_gate_inst (
        .advert(advert_if),
        .rob_head_index(rob_head_index),
        .ld_valid(ld_valid),
        .ld_is_io(ld_is_io),
        .ld_rob_index(ld_rob_index),
        .ld_stall(ld_stall)
    );

    assign mem_active = advert_if.advert.mem_active;
    assign mem_oldest = advert_if.advert.mem_oldest;
    assign io_active  = advert_if.advert.io_active;
    assign io_oldest  = advert_if.advert.io_oldest;

endmodule

/* test/stamofu_aq_tb.sv */
// --------------------
// acquire tracking testbench
// table of stimulus rows with expected outputs, checked every cycle
// --------------------

`timescale 1ns/1ps

module stamofu_aq_tb;

    localparam int NUM_ROWS    = 30;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT = NUM_ROWS + RESET_CYCLES + 20;

    localparam stamofu_pkg::stamofu_op_e ST = stamofu_pkg::OP_STORE;
    localparam stamofu_pkg::stamofu_op_e AM = stamofu_pkg::OP_AMO;
    localparam stamofu_pkg::stamofu_op_e FN = stamofu_pkg::OP_FENCE;

    // columns: dispatch | upd0 | upd1 | deq kill head | load
    typedef struct {
        // dispatch
        logic                     dv;
        stamofu_pkg::stamofu_op_e op;
        logic                     aq;
        logic                     fm;
        logic                     fi;
        stamofu_pkg::rob_index_t  drob;
        // update bank 0
        logic                     u0v;
        logic                     u0m;
        logic                     u0i;
        stamofu_pkg::rob_index_t  u0r;
        // update bank 1
        logic                     u1v;
        logic                     u1m;
        logic                     u1i;
        stamofu_pkg::rob_index_t  u1r;
        // dequeue, kill and head
        logic                     deq;
        logic                     kv;
        stamofu_pkg::rob_index_t  krel;
        stamofu_pkg::rob_index_t  head;
        // load query
        logic                     lv;
        logic                     lio;
        stamofu_pkg::rob_index_t  lrob;
    } stim_t;

    // expected advert, deq index check enable, deq index, enq_ready, ld_stall
    typedef struct {
        stamofu_pkg::aq_advert_t adv;
        logic                    chk_deq;
        stamofu_pkg::rob_index_t deq;
        logic                    rdy;
        logic                    stall;
    } expect_t;

    logic CLK;
    logic nRST;
    logic dispatch_valid;
    stamofu_pkg::stamofu_op_e dispatch_op;
    logic dispatch_aq;
    logic dispatch_fence_mem;
    logic dispatch_fence_io;
    stamofu_pkg::rob_index_t dispatch_rob_index;
    logic enq_ready;
    logic upd0_valid, upd0_mem_aq, upd0_io_aq;
    stamofu_pkg::rob_index_t upd0_rob_index;
    logic upd1_valid, upd1_mem_aq, upd1_io_aq;
    stamofu_pkg::rob_index_t upd1_rob_index;
    logic deq_valid;
    stamofu_pkg::rob_index_t deq_rob_index;
    stamofu_pkg::rob_index_t rob_head_index;
    logic rob_kill_valid;
    stamofu_pkg::rob_index_t rob_kill_rel_index;
    logic mem_active, io_active;
    stamofu_pkg::rob_index_t mem_oldest, io_oldest;
    logic ld_valid, ld_is_io;
    stamofu_pkg::rob_index_t ld_rob_index;
    logic ld_stall;

    stim_t   stim [NUM_ROWS];
    expect_t expv [NUM_ROWS];
    int      cycles = 0;
    int      errors;

    stamofu_aq_top stamofu_aq_top_inst (.*);

    always #50 CLK = ~CLK;

    // --------------------
    // checks
    // --------------------

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // index fields only count while the matching active bit is set
    task automatic check_advert(input stamofu_pkg::aq_advert_t got,
                                input stamofu_pkg::aq_advert_t exp, input int row);
        if (got.mem_active !== exp.mem_active || got.io_active !== exp.io_active
            || (exp.mem_active && got.mem_oldest !== exp.mem_oldest)
            || (exp.io_active && got.io_oldest !== exp.io_oldest)) begin
            errors++;
            report_mismatch($sformatf("row %0d advert got %p expected %p", row, got, exp));
        end
    endtask

    task automatic check_rob_index(input stamofu_pkg::rob_index_t got,
                                   input stamofu_pkg::rob_index_t exp, input string msg);
        if (got !== exp) begin
            errors++;
            report_mismatch($sformatf("%s got %0d expected %0d", msg, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            errors++;
            report_mismatch($sformatf("%s got %b expected %b", msg, got, exp));
        end
    endtask

    // --------------------
    // table
    // --------------------

    task automatic fill_table();
        // reset state, first dispatches
        stim[0]  = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   1,0,5};
        stim[1]  = '{1,ST,0,0,0,10,  0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[2]  = '{1,AM,1,0,0,11,  0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[3]  = '{1,FN,0,0,1,12,  0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[4]  = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[5]  = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   1,1,13};
        stim[6]  = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   1,0,13};
        // late updates, then both banks on one entry
        stim[7]  = '{0,ST,0,0,0,0,   0,0,0,0,  1,1,1,11, 0,0,0,0,   1,0,9};
        stim[8]  = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[9]  = '{0,ST,0,0,0,0,   1,1,0,11, 1,0,1,11, 0,0,0,0,   0,0,0};
        stim[10] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        // dequeues, one alongside an enqueue
        stim[11] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  1,0,0,0,   0,0,0};
        stim[12] = '{1,ST,0,0,0,13,  0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[13] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  1,0,0,0,   0,0,0};
        stim[14] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        stim[15] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  1,0,0,0,   0,0,0};
        stim[16] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  1,0,0,0,   0,0,0};
        stim[17] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,0,   0,0,0};
        // head at 126, fill across the index wrap
        stim[18] = '{1,AM,1,0,0,126, 0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        stim[19] = '{1,FN,0,1,0,127, 0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        stim[20] = '{1,FN,0,0,1,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        stim[21] = '{1,AM,1,0,0,1,   0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        stim[22] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        stim[23] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        // kill everything younger than relative index 1
        stim[24] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,1,1,126, 1,1,1};
        stim[25] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 1,1,1};
        stim[26] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 1,1,1};
        stim[27] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  1,0,0,126, 1,0,2};
        stim[28] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};
        stim[29] = '{0,ST,0,0,0,0,   0,0,0,0,  0,0,0,0,  0,0,0,126, 0,0,0};

        expv[0]  = '{'{0,0,0,0},     1,0,1,0};
        expv[1]  = '{'{0,0,0,0},     1,0,1,0};
        expv[2]  = '{'{0,0,0,0},     0,0,1,0};
        expv[3]  = '{'{0,0,0,0},     1,10,1,0};
        expv[4]  = '{'{0,0,0,0},     1,10,1,0};
        expv[5]  = '{'{1,11,0,0},    1,10,1,0};
        expv[6]  = '{'{1,11,1,12},   1,10,1,1};
        expv[7]  = '{'{1,11,1,12},   1,10,1,0};
        expv[8]  = '{'{1,11,1,12},   1,10,1,0};
        expv[9]  = '{'{1,11,1,11},   1,10,1,0};
        expv[10] = '{'{1,11,1,11},   1,10,1,0};
        expv[11] = '{'{1,11,1,12},   1,10,1,0};
        expv[12] = '{'{1,11,1,12},   1,11,1,0};
        expv[13] = '{'{1,11,1,12},   1,11,1,0};
        expv[14] = '{'{1,11,1,12},   1,12,1,0};
        expv[15] = '{'{0,0,1,12},    1,12,1,0};
        expv[16] = '{'{0,0,1,12},    1,13,1,0};
        expv[17] = '{'{0,0,0,0},     0,0,1,0};
        expv[18] = '{'{0,0,0,0},     0,0,1,0};
        expv[19] = '{'{0,0,0,0},     0,0,1,0};
        expv[20] = '{'{0,0,0,0},     1,126,1,0};
        expv[21] = '{'{1,126,0,0},   1,126,1,0};
        expv[22] = '{'{1,126,0,0},   1,126,0,0};
        expv[23] = '{'{1,126,1,0},   1,126,0,0};
        expv[24] = '{'{1,126,1,0},   1,126,0,1};
        expv[25] = '{'{1,126,1,0},   1,126,0,1};
        expv[26] = '{'{1,126,0,0},   1,126,0,0};
        expv[27] = '{'{1,126,0,0},   1,126,0,1};
        expv[28] = '{'{1,126,0,0},   1,127,1,0};
        expv[29] = '{'{1,127,0,0},   1,127,1,0};
    endtask

    task automatic apply_row(input stim_t s);
        dispatch_valid     <= s.dv;
        dispatch_op        <= s.op;
        dispatch_aq        <= s.aq;
        dispatch_fence_mem <= s.fm;
        dispatch_fence_io  <= s.fi;
        dispatch_rob_index <= s.drob;
        upd0_valid         <= s.u0v;
        upd0_mem_aq        <= s.u0m;
        upd0_io_aq         <= s.u0i;
        upd0_rob_index     <= s.u0r;
        upd1_valid         <= s.u1v;
        upd1_mem_aq        <= s.u1m;
        upd1_io_aq         <= s.u1i;
        upd1_rob_index     <= s.u1r;
        deq_valid          <= s.deq;
        rob_kill_valid     <= s.kv;
        rob_kill_rel_index <= s.krel;
        rob_head_index     <= s.head;
        ld_valid           <= s.lv;
        ld_is_io           <= s.lio;
        ld_rob_index       <= s.lrob;
    endtask

    // --------------------
    // run limit
    // --------------------

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the test table did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1, "run limit reached");
        end
    end

    initial begin
        stamofu_pkg::aq_advert_t got;
        CLK = 1'b0;
        nRST <= 1'b0;
        errors = 0;
        apply_row('{0,ST,0,0,0,0, 0,0,0,0, 0,0,0,0, 0,0,0,0, 0,0,0});
        fill_table();
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge CLK);
            apply_row(stim[r]);
            // outputs settle well before the falling edge
            @(negedge CLK);
            got = '{mem_active, mem_oldest, io_active, io_oldest};
            check_advert(got, expv[r].adv, r);
            if (expv[r].chk_deq) begin
                check_rob_index(deq_rob_index, expv[r].deq,
                                $sformatf("row %0d deq_rob_index", r));
            end
            check_flag(enq_ready, expv[r].rdy, $sformatf("row %0d enq_ready", r));
            check_flag(ld_stall, expv[r].stall, $sformatf("row %0d ld_stall", r));
        end
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/stamofu_pkg.sv
design/stamofu_aq_if.sv
design/pe_lsb.sv
design/stamofu_dispatch.sv
design/stamofu_aq.sv
design/stamofu_load_gate.sv
design/stamofu_aq_top.sv
test/stamofu_aq_tb.sv

/* Bender.yml */
package:
  name: stamofu_aq

sources:
  - include_dirs:
      - design
    files:
      - design/stamofu_pkg.sv
      - design/stamofu_aq_if.sv
      - design/pe_lsb.sv
      - design/stamofu_dispatch.sv
      - design/stamofu_aq.sv
      - design/stamofu_load_gate.sv
      - design/stamofu_aq_top.sv
  - target: test
    files:
      - test/stamofu_aq_tb.sv
